// ==== Bender.yml ====
package:
  name: cpu_exec

sources:
  - logic/isa_pkg.sv
  - logic/bus_pkg.sv
  - logic/instr_decoder.sv
  - logic/reg_file.sv
  - logic/alu.sv
  - logic/exec_sequencer.sv
  - logic/cpu_exec_top.sv
  - target: test
    files:
      - tb/cpu_exec_sva.sv
      - tb/cpu_exec_tb.sv

// ==== logic/alu.sv ====
// registered alu: arithmetic, logic, shifts, address generation, condition evaluation, flags
`timescale 1ns/1ps

module alu import isa_pkg::*; (
    input  logic        clk,
    input  logic        en,
    input  dec_op_t     op,
    input  logic [15:0] rd_data,
    input  logic [15:0] rs_data,
    input  flags_t      flags_in,
    output alu_out_t    res
);

    logic [15:0] data1;
    logic [15:0] data2;
    logic [16:0] sum;
    logic        ov_op;
    logic        sign1;
    logic        sign2;
    logic        take;
    logic [15:0] mem_data;
    alu_out_t    res_next;

    function automatic logic cond_true(input flags_t f, input cond_e code);
        logic z;
        logic c;
        logic s;
        logic v;
        z = f[flag_zero];
        c = f[flag_carry];
        s = f[flag_sign];
        v = f[flag_overflow];
        case (code)
            cond_always: cond_true = 1'b1;
            cond_eq:     cond_true = z;
            cond_ne:     cond_true = ~z;
            cond_os:     cond_true = v;
            cond_oc:     cond_true = ~v;
            cond_cs:     cond_true = c;
            cond_cc:     cond_true = ~c;
            cond_n:      cond_true = s;
            cond_p:      cond_true = ~s;
            cond_l:      cond_true = s ^ v;
            cond_ge:     cond_true = ~(s ^ v);
            cond_le:     cond_true = (s ^ v) | z;
            cond_g:      cond_true = ~(s ^ v) & ~z;
            cond_hi:     cond_true = ~c & ~z;
            cond_ls:     cond_true = c | z;
            default:     cond_true = 1'b0;
        endcase
    endfunction

    assign data1 = rd_data;
    assign data2 = op.imm_en ? op.imm : rs_data;
    assign take  = cond_true(flags_in, op.cond);

    always_comb begin
        sum      = '0;
        ov_op    = 1'b0;
        sign1    = data1[15];
        sign2    = data2[15];
        mem_data = data1;

        case (op.opcode)
            op_add: begin
                sum   = {1'b0, data1} + {1'b0, data2};
                ov_op = 1'b1;
            end
            op_adc: begin
                sum   = {1'b0, data1} + {1'b0, data2} + {16'h0000, flags_in[flag_carry]};
                ov_op = 1'b1;
            end
            // bit 16 becomes the borrow
            op_sub, op_cmp: begin
                sum   = {1'b0, data1} - {1'b0, data2};
                ov_op = 1'b1;
                sign2 = ~data2[15];
            end
            op_sbb: begin
                sum   = {1'b0, data1} - {1'b0, data2} - {16'h0000, flags_in[flag_carry]};
                ov_op = 1'b1;
                sign2 = ~data2[15];
            end
            op_mov:  sum = {1'b0, data2};
            op_and:  sum = {1'b0, data1 & data2};
            op_test: sum = {1'b0, data1 & data2};
            op_or:   sum = {1'b0, data1 | data2};
            op_xor:  sum = {1'b0, data1 ^ data2};
            op_not:  sum = {1'b0, ~data1};
            op_neg:  sum = {1'b0, 16'h0000 - data1};
            // last bit shifted out of the top lands in bit 16
            op_shl:  sum = {1'b0, data1} << data2[3:0];
            op_shr:  sum = {1'b0, data1} >> data2[3:0];
            op_jmp:  sum = {1'b0, op.imm_en ? op.imm : data1};
            op_set:  sum = {16'h0000, take};
            op_ld, op_st: begin
                sum = {1'b0, op.imm_en ? rs_data + op.imm : rs_data};
            end
            // rs is the stack pointer here
            op_push: begin
                sum      = {1'b0, rs_data - 16'd2};
                mem_data = op.imm_en ? op.imm : data1;
            end
            op_pop:  sum = {1'b0, rs_data};
            default: sum = '0;
        endcase

        res_next.result                  = sum[15:0];
        res_next.flags[flag_zero]        = (sum[15:0] == 16'h0000);
        res_next.flags[flag_carry]       = sum[16];
        res_next.flags[flag_sign]        = sum[15];
        res_next.flags[flag_overflow]    = ov_op && (sign1 == sign2) && (sign1 != sum[15]);
        res_next.take                    = take;
        res_next.mem_data                = mem_data;
    end

    always_ff @(posedge clk) begin
        if (en) begin
            res <= res_next;
        end
    end

endmodule

// ==== logic/bus_pkg.sv ====
// wishbone classic request and response structs, host port address map
package bus_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [15:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // host port map
    localparam logic [15:0] host_adr_instr    = 16'h0000;
    // r0 to r7 at base + index
    localparam logic [15:0] host_adr_reg_base = 16'h0010;
    localparam logic [15:0] host_adr_flags    = 16'h0020;
    localparam logic [15:0] host_adr_pc       = 16'h0021;

endpackage

// ==== logic/cpu_exec_top.sv ====
// execute core top level: decoder, register file, alu and sequencer
`timescale 1ns/1ps

module cpu_exec_top import isa_pkg::*, bus_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t host_req,
    output wb_rsp_t host_rsp,
    output wb_req_t mem_req,
    input  wb_rsp_t mem_rsp
);

    instr_t      instr;
    dec_op_t     dec;
    alu_out_t    res;
    flags_t      flags;
    logic        alu_en;
    logic [15:0] rd_data;
    logic [15:0] rs_data;
    logic        rf_wr_en;
    logic [2:0]  rf_wr_sel;
    logic [15:0] rf_wr_data;
    logic        sp_wr_en;
    logic [15:0] sp_data;
    logic [2:0]  dbg_sel;

    instr_decoder u_dec (
        .instr (instr),
        .dec   (dec)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst      (rst),
        .rd_sel   (dbg_sel),
        .rs_sel   (dec.rs),
        .rd_data  (rd_data),
        .rs_data  (rs_data),
        .wr_en    (rf_wr_en),
        .wr_sel   (rf_wr_sel),
        .wr_data  (rf_wr_data),
        .sp_wr_en (sp_wr_en),
        .sp_data  (sp_data)
    );

    alu u_alu (
        .clk      (clk),
        .en       (alu_en),
        .op       (dec),
        .rd_data  (rd_data),
        .rs_data  (rs_data),
        .flags_in (flags),
        .res      (res)
    );

    exec_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .instr      (instr),
        .dec        (dec),
        .alu_en     (alu_en),
        .res        (res),
        .rd_data    (rd_data),
        .rf_wr_en   (rf_wr_en),
        .rf_wr_sel  (rf_wr_sel),
        .rf_wr_data (rf_wr_data),
        .sp_wr_en   (sp_wr_en),
        .sp_data    (sp_data),
        .flags      (flags),
        .dbg_sel    (dbg_sel)
    );

endmodule

// ==== logic/exec_sequencer.sv ====
// execute sequencer: host slave port, retirement, flags and pc, data-bus master
`timescale 1ns/1ps

module exec_sequencer import isa_pkg::*, bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  wb_req_t     host_req,
    output wb_rsp_t     host_rsp,
    output wb_req_t     mem_req,
    input  wb_rsp_t     mem_rsp,
    output instr_t      instr,
    input  dec_op_t     dec,
    output logic        alu_en,
    input  alu_out_t    res,
    input  logic [15:0] rd_data,
    output logic        rf_wr_en,
    output logic [2:0]  rf_wr_sel,
    output logic [15:0] rf_wr_data,
    output logic        sp_wr_en,
    output logic [15:0] sp_data,
    output flags_t      flags,
    output logic [2:0]  dbg_sel
);

    typedef enum logic [1:0] {st_idle, st_exec, st_mem, st_resp} state_e;

    state_e      state;
    instr_t      instr_q;
    flags_t      flags_q;
    logic [15:0] pc_q;
    logic        retire_q;
    logic [31:0] host_dat_q;
    logic [15:0] ld_data_q;
    logic        host_sel;
    logic        instr_wr;
    logic        stack_op;
    logic        retiring;
    logic [31:0] rd_reply;

    assign host_sel = host_req.cyc && host_req.stb;
    assign instr_wr = host_sel && host_req.we && (host_req.adr == host_adr_instr);
    assign stack_op = (instr_q.opcode == op_push) || (instr_q.opcode == op_pop);
    assign retiring = (state == st_resp) && retire_q;

    // push and pop always address through r7
    always_comb begin
        instr = instr_q;
        if (stack_op) begin
            instr.rs = 3'd7;
        end
    end

    // rd port serves host register reads while idle
    assign dbg_sel = (state == st_idle) ? host_req.adr[2:0] : dec.rd;
    assign alu_en  = (state == st_exec);

    always_comb begin
        rd_reply = '0;
        if (host_req.adr[15:3] == host_adr_reg_base[15:3]) begin
            rd_reply = {16'h0000, rd_data};
        end else if (host_req.adr == host_adr_flags) begin
            rd_reply = {28'h0000000, flags_q};
        end else if (host_req.adr == host_adr_pc) begin
            rd_reply = {16'h0000, pc_q};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            retire_q <= 1'b0;
            flags_q  <= '0;
            pc_q     <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (host_sel) begin
                        retire_q <= instr_wr;
                        state    <= instr_wr ? st_exec : st_resp;
                    end
                end
                st_exec: state <= dec.is_mem ? st_mem : st_resp;
                st_mem: begin
                    if (mem_rsp.ack) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    state <= st_idle;
                    if (retire_q) begin
                        if (dec.sets_flags) begin
                            flags_q <= res.flags;
                        end
                        if (dec.is_jump && res.take) begin
                            pc_q <= res.result;
                        end else begin
                            pc_q <= pc_q + 16'd1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && host_sel) begin
            host_dat_q <= host_req.we ? 32'h0 : rd_reply;
            if (instr_wr) begin
                instr_q <= host_req.dat;
            end
        end
        if (state == st_mem && mem_rsp.ack) begin
            ld_data_q <= mem_rsp.dat[15:0];
        end
    end

    assign host_rsp.ack = (state == st_resp);
    assign host_rsp.dat = host_dat_q;

    // request held from state and alu output, both stable until ack
    always_comb begin
        mem_req = '0;
        if (state == st_mem) begin
            mem_req.cyc = 1'b1;
            mem_req.stb = 1'b1;
            mem_req.we  = (dec.opcode == op_st) || (dec.opcode == op_push);
            mem_req.adr = res.result;
            mem_req.dat = {16'h0000, res.mem_data};
        end
    end

    assign rf_wr_en   = retiring && dec.writes_rd;
    assign rf_wr_sel  = dec.rd;
    assign rf_wr_data = dec.is_mem ? ld_data_q : res.result;
    assign sp_wr_en   = retiring && stack_op;
    assign sp_data    = (dec.opcode == op_push) ? res.result : res.result + 16'd2;
    assign flags      = flags_q;

endmodule

// ==== logic/instr_decoder.sv ====
// instruction decoder with field extraction and operation classification
`timescale 1ns/1ps

module instr_decoder import isa_pkg::*; (
    input  instr_t  instr,
    output dec_op_t dec
);

    always_comb begin
        dec.opcode     = instr.opcode;
        dec.rd         = instr.rd;
        dec.rs         = instr.rs;
        dec.cond       = instr.cond;
        dec.imm_en     = instr.imm_en;
        dec.imm        = instr.imm;
        dec.writes_rd  = 1'b0;
        dec.sets_flags = 1'b0;
        dec.is_mem     = 1'b0;
        dec.is_jump    = 1'b0;

        case (instr.opcode)
            op_add, op_sub, op_adc, op_sbb, op_mov, op_and, op_or, op_xor,
            op_not, op_neg, op_shl, op_shr: begin
                dec.writes_rd  = 1'b1;
                dec.sets_flags = 1'b1;
            end
            // flags only with the destination untouched
            op_cmp, op_test: begin
                dec.sets_flags = 1'b1;
            end
            op_jmp: begin
                dec.is_jump = 1'b1;
            end
            op_set: begin
                dec.writes_rd = 1'b1;
            end
            op_ld, op_pop: begin
                dec.writes_rd = 1'b1;
                dec.is_mem    = 1'b1;
            end
            op_st, op_push: begin
                dec.is_mem = 1'b1;
            end
            default: begin
                // nop and unknown encodings only advance pc
                dec.opcode = op_nop;
            end
        endcase
    end

endmodule

// ==== logic/isa_pkg.sv ====
// opcode and condition enums, flag bit positions, instruction, decoded-op and alu result types
package isa_pkg;

    typedef enum logic [4:0] {
        op_nop  = 5'd0,
        op_add  = 5'd1,
        op_sub  = 5'd2,
        op_adc  = 5'd3,
        op_sbb  = 5'd4,
        op_cmp  = 5'd5,
        op_mov  = 5'd6,
        op_and  = 5'd7,
        op_or   = 5'd8,
        op_xor  = 5'd9,
        op_not  = 5'd10,
        op_neg  = 5'd11,
        op_shl  = 5'd12,
        op_shr  = 5'd13,
        op_test = 5'd14,
        op_jmp  = 5'd15,
        op_set  = 5'd16,
        op_ld   = 5'd17,
        op_st   = 5'd18,
        op_push = 5'd19,
        op_pop  = 5'd20
    } opcode_e;

    typedef enum logic [3:0] {
        cond_always = 4'd0,
        cond_eq     = 4'd1,
        cond_ne     = 4'd2,
        cond_os     = 4'd3,
        cond_oc     = 4'd4,
        cond_cs     = 4'd5,
        cond_cc     = 4'd6,
        cond_n      = 4'd7,
        cond_p      = 4'd8,
        cond_l      = 4'd9,
        cond_ge     = 4'd10,
        cond_le     = 4'd11,
        cond_g      = 4'd12,
        cond_hi     = 4'd13,
        cond_ls     = 4'd14
    } cond_e;

    // bit positions inside flags_t
    localparam int flag_zero     = 0;
    localparam int flag_carry    = 1;
    localparam int flag_sign     = 2;
    localparam int flag_overflow = 3;

    typedef logic [3:0] flags_t;

    // host-issued instruction word, msb first
    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  rd;
        logic [2:0]  rs;
        cond_e       cond;
        logic        imm_en;
        logic [15:0] imm;
    } instr_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  rd;
        logic [2:0]  rs;
        cond_e       cond;
        logic        imm_en;
        logic [15:0] imm;
        logic        writes_rd;
        logic        sets_flags;
        logic        is_mem;
        logic        is_jump;
    } dec_op_t;

    typedef struct packed {
        logic [15:0] result;
        flags_t      flags;
        logic        take;
        logic [15:0] mem_data;
    } alu_out_t;

endpackage

// ==== logic/reg_file.sv ====
// eight-entry 16-bit register file, two read ports, result and stack-pointer write ports
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  rd_sel,
    input  logic [2:0]  rs_sel,
    output logic [15:0] rd_data,
    output logic [15:0] rs_data,
    input  logic        wr_en,
    input  logic [2:0]  wr_sel,
    input  logic [15:0] wr_data,
    input  logic        sp_wr_en,
    input  logic [15:0] sp_data
);

    logic [15:0] regs [8];

    assign rd_data = regs[rd_sel];
    assign rs_data = regs[rs_sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // r7 doubles as stack pointer
            if (sp_wr_en) begin
                regs[7] <= sp_data;
            end
            // result port comes last so it wins on r7, e.g. pop r7
            if (wr_en) begin
                regs[wr_sel] <= wr_data;
            end
        end
    end

endmodule

// ==== src.f ====
logic/isa_pkg.sv
logic/bus_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/exec_sequencer.sv
logic/cpu_exec_top.sv
tb/cpu_exec_sva.sv
tb/cpu_exec_tb.sv

// ==== tb/cpu_exec_sva.sv ====
// wishbone classic protocol and reset assertions for the execute core
`timescale 1ns/1ps

module cpu_exec_sva import bus_pkg::*; (
    input logic    clk,
    input logic    rst,
    input wb_req_t host_req,
    input wb_rsp_t host_rsp,
    input wb_req_t mem_req,
    input wb_rsp_t mem_rsp
);

    // host ack is a single-cycle pulse
    host_ack_pulse: assert property (
        @(posedge clk) disable iff (rst)
        host_rsp.ack |=> !host_rsp.ack
    ) else $error("host ack held for more than one cycle");

    host_ack_with_stb: assert property (
        @(posedge clk) disable iff (rst)
        host_rsp.ack |-> (host_req.cyc && host_req.stb)
    ) else $error("host ack raised without an active strobe");

    // master keeps address, data and we until the slave answers
    mem_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        (mem_req.cyc && mem_req.stb && !mem_rsp.ack) |=> $stable(mem_req)
    ) else $error("data-bus request changed before ack");

    reset_quiet: assert property (
        @(posedge clk)
        (rst && $past(rst)) |-> (!host_rsp.ack && !mem_req.cyc && !mem_req.stb && !mem_req.we)
    ) else $error("bus outputs active during reset");

endmodule

// ==== tb/cpu_exec_tb.sv ====
// testbench for the execute core: host driver, memory model, reference model, stimulus table
`timescale 1ns/1ps

module cpu_exec_tb import isa_pkg::*, bus_pkg::*; ();

    localparam int ack_timeout = 64;

    // one table row: instruction word and the values expected after it retires
    typedef struct packed {
        logic [31:0] word;
        logic [15:0] exp_rd;
        logic [15:0] exp_sp;
        flags_t      exp_flags;
        logic [15:0] exp_pc;
        logic        mem_chk;
        logic [15:0] mem_adr;
        logic [15:0] mem_word;
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    wb_req_t     host_req;
    wb_rsp_t     host_rsp;
    wb_req_t     mem_req;
    wb_rsp_t     mem_rsp = '0;
    logic [31:0] seed = 32'hc49951bc;
    int          errors = 0;
    int          checks = 0;
    int          wait_left = 2;
    logic [15:0] mem_a1;
    logic [7:0]  mem [65536];
    row_t        table_q [$];

    // reference model state
    logic [15:0] m_regs [8];
    flags_t      m_flags;
    logic [15:0] m_pc;
    logic [7:0]  m_mem [65536];

    cpu_exec_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    bind cpu_exec_top cpu_exec_sva u_sva (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    always #20 clk = ~clk;

    // little-endian byte memory with 0 to 3 random wait states per access
    always @(negedge clk) begin
        mem_a1 = mem_req.adr + 16'd1;
        if (mem_rsp.ack) begin
            mem_rsp.ack = 1'b0;
            wait_left = $random(seed) & 3;
        end else if (mem_req.cyc && mem_req.stb) begin
            if (wait_left > 0) begin
                wait_left--;
            end else begin
                if (mem_req.we) begin
                    mem[mem_req.adr] = mem_req.dat[7:0];
                    mem[mem_a1] = mem_req.dat[15:8];
                    mem_rsp.dat = '0;
                end else begin
                    mem_rsp.dat = {16'h0000, mem[mem_a1], mem[mem_req.adr]};
                end
                mem_rsp.ack = 1'b1;
            end
        end
    end

    task automatic report_counts();
        $display("checks: %0d, errors: %0d", checks, errors);
    endtask

    task automatic host_xfer(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(negedge clk);
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = adr;
        host_req.dat = wdat;
        while (!host_rsp.ack && waited < ack_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!host_rsp.ack) begin
            $display("ERROR: host port gave no ack within %0d cycles, address %h", waited, adr);
            errors++;
            report_counts();
            $display("Test failures found");
            $finish;
        end else begin
            rdat = host_rsp.dat;
            // release after the edge that sampled ack
            @(negedge clk);
            host_req = '0;
        end
    endtask

    task automatic check_word(input string what, input int idx, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH time=%0t: row %0d %s is %h, expected %h", $time, idx, what, got, exp);
        end
    endtask

    function automatic logic cond_holds(input flags_t f, input logic [3:0] cc);
        logic lt;
        lt = f[flag_sign] ^ f[flag_overflow];
        case (cc)
            cond_always: return 1'b1;
            cond_eq:     return f[flag_zero];
            cond_ne:     return !f[flag_zero];
            cond_os:     return f[flag_overflow];
            cond_oc:     return !f[flag_overflow];
            cond_cs:     return f[flag_carry];
            cond_cc:     return !f[flag_carry];
            cond_n:      return f[flag_sign];
            cond_p:      return !f[flag_sign];
            cond_l:      return lt;
            cond_ge:     return !lt;
            cond_le:     return lt || f[flag_zero];
            cond_g:      return !lt && !f[flag_zero];
            cond_hi:     return !f[flag_carry] && !f[flag_zero];
            cond_ls:     return f[flag_carry] || f[flag_zero];
            default:     return 1'b0;
        endcase
    endfunction

    task automatic run_model(input logic [31:0] word, output row_t row);
        instr_t      ins;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] y;
        logic [15:0] adr;
        logic [16:0] wide;
        logic        cin;
        logic        c;
        logic        v;
        logic        upd;
        logic        wr;
        ins = word;
        a = m_regs[ins.rd];
        b = ins.imm_en ? ins.imm : m_regs[ins.rs];
        y = '0;
        c = 1'b0;
        v = 1'b0;
        upd = 1'b0;
        wr = 1'b0;
        row = '0;
        row.word = word;
        m_pc = m_pc + 16'd1;
        case (ins.opcode)
            op_add, op_adc: begin
                cin = (ins.opcode == op_adc) && m_flags[flag_carry];
                wide = {1'b0, a} + {1'b0, b} + {16'h0000, cin};
                y = wide[15:0];
                c = wide[16];
                v = (a[15] == b[15]) && (y[15] != a[15]);
                upd = 1'b1;
                wr = 1'b1;
            end
            op_sub, op_sbb, op_cmp: begin
                cin = (ins.opcode == op_sbb) && m_flags[flag_carry];
                wide = {1'b0, a} - {1'b0, b} - {16'h0000, cin};
                y = wide[15:0];
                c = wide[16];
                v = (a[15] != b[15]) && (y[15] != a[15]);
                upd = 1'b1;
                wr = (ins.opcode != op_cmp);
            end
            op_mov, op_and, op_or, op_xor, op_not, op_neg, op_test: begin
                case (ins.opcode)
                    op_mov:  y = b;
                    op_or:   y = a | b;
                    op_xor:  y = a ^ b;
                    op_not:  y = ~a;
                    op_neg:  y = -a;
                    default: y = a & b;
                endcase
                upd = 1'b1;
                wr = (ins.opcode != op_test);
            end
            op_shl: begin
                wide = {1'b0, a} << b[3:0];
                y = wide[15:0];
                c = wide[16];
                upd = 1'b1;
                wr = 1'b1;
            end
            // nothing reaches bit 16 on a right shift
            op_shr: begin
                y = a >> b[3:0];
                upd = 1'b1;
                wr = 1'b1;
            end
            op_jmp: begin
                if (cond_holds(m_flags, ins.cond)) begin
                    m_pc = ins.imm_en ? ins.imm : a;
                end
            end
            op_set: begin
                y = {15'h0000, cond_holds(m_flags, ins.cond)};
                wr = 1'b1;
            end
            op_ld, op_st: begin
                adr = ins.imm_en ? m_regs[ins.rs] + ins.imm : m_regs[ins.rs];
                if (ins.opcode == op_ld) begin
                    y = {m_mem[adr + 16'd1], m_mem[adr]};
                    wr = 1'b1;
                end else begin
                    m_mem[adr] = a[7:0];
                    m_mem[adr + 16'd1] = a[15:8];
                    row.mem_chk = 1'b1;
                    row.mem_adr = adr;
                    row.mem_word = a;
                end
            end
            op_push: begin
                adr = m_regs[7] - 16'd2;
                y = ins.imm_en ? ins.imm : a;
                m_mem[adr] = y[7:0];
                m_mem[adr + 16'd1] = y[15:8];
                m_regs[7] = adr;
                row.mem_chk = 1'b1;
                row.mem_adr = adr;
                row.mem_word = y;
            end
            // stack pointer first so pop r7 ends with the popped value
            op_pop: begin
                adr = m_regs[7];
                y = {m_mem[adr + 16'd1], m_mem[adr]};
                m_regs[7] = adr + 16'd2;
                wr = 1'b1;
            end
            default: begin
            end
        endcase
        if (wr) begin
            m_regs[ins.rd] = y;
        end
        if (upd) begin
            m_flags[flag_zero] = (y == 16'h0000);
            m_flags[flag_carry] = c;
            m_flags[flag_sign] = y[15];
            m_flags[flag_overflow] = v;
        end
        row.exp_rd = m_regs[ins.rd];
        row.exp_sp = m_regs[7];
        row.exp_flags = m_flags;
        row.exp_pc = m_pc;
    endtask

    task automatic add_row(input logic [4:0] op, input logic [2:0] rd, input logic [2:0] rs,
                           input logic [3:0] cc, input logic ie, input logic [15:0] imm);
        row_t r;
        run_model({op, rd, rs, cc, ie, imm}, r);
        table_q.push_back(r);
    endtask

    // one compare, then every condition through set and jmp
    task automatic cond_sweep(input logic [2:0] rd, input logic [15:0] imm);
        add_row(op_cmp, rd, 3'd0, cond_always, 1'b1, imm);
        for (int k = 0; k < 15; k++) begin
            add_row(op_set, 3'd3, 3'd0, k[3:0], 1'b0, 16'h0000);
            add_row(op_jmp, 3'd0, 3'd0, k[3:0], 1'b1, 16'h0100 + 16'(k));
        end
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        // add and subtract family around the sign boundary
        add_row(op_mov, 3'd1, 3'd0, cond_always, 1'b1, 16'h7fff);
        add_row(op_mov, 3'd2, 3'd0, cond_always, 1'b1, 16'h0001);
        add_row(op_add, 3'd1, 3'd2, cond_always, 1'b0, 16'h0000);
        add_row(op_mov, 3'd3, 3'd0, cond_always, 1'b1, 16'hffff);
        add_row(op_add, 3'd3, 3'd0, cond_always, 1'b1, 16'h0001);
        add_row(op_adc, 3'd2, 3'd0, cond_always, 1'b1, 16'h0010);
        add_row(op_sub, 3'd4, 3'd0, cond_always, 1'b1, 16'h0001);
        add_row(op_sbb, 3'd4, 3'd2, cond_always, 1'b0, 16'h0000);
        add_row(op_mov, 3'd5, 3'd0, cond_always, 1'b1, 16'h8000);
        add_row(op_sub, 3'd5, 3'd0, cond_always, 1'b1, 16'h0001);
        add_row(op_sub, 3'd6, 3'd0, cond_always, 1'b1, 16'h0005);
        add_row(op_adc, 3'd6, 3'd1, cond_always, 1'b0, 16'h0000);
        add_row(op_neg, 3'd1, 3'd0, cond_always, 1'b0, 16'h0000);
        add_row(op_neg, 3'd2, 3'd0, cond_always, 1'b0, 16'h0000);
        add_row(op_neg, 3'd0, 3'd0, cond_always, 1'b0, 16'h0000);
        // logic, shifts, register moves
        add_row(op_mov, 3'd6, 3'd5, cond_always, 1'b0, 16'h0000);
        add_row(op_and, 3'd6, 3'd0, cond_always, 1'b1, 16'h0ff0);
        add_row(op_or,  3'd6, 3'd2, cond_always, 1'b0, 16'h0000);
        add_row(op_xor, 3'd6, 3'd0, cond_always, 1'b1, 16'hffff);
        add_row(op_not, 3'd6, 3'd0, cond_always, 1'b0, 16'h0000);
        add_row(op_mov, 3'd4, 3'd0, cond_always, 1'b1, 16'hc001);
        add_row(op_shl, 3'd4, 3'd0, cond_always, 1'b1, 16'h0001);
        add_row(op_shr, 3'd4, 3'd0, cond_always, 1'b1, 16'h0003);
        add_row(op_shl, 3'd4, 3'd2, cond_always, 1'b0, 16'h0000);
        add_row(op_shr, 3'd4, 3'd0, cond_always, 1'b1, 16'h0010);
        add_row(op_test, 3'd1, 3'd0, cond_always, 1'b1, 16'h0000);
        add_row(op_test, 3'd1, 3'd1, cond_always, 1'b0, 16'h0000);
        add_row(op_cmp, 3'd1, 3'd2, cond_always, 1'b0, 16'h0000);
        // conditions under zero, borrow, positive and overflow results
        add_row(op_mov, 3'd1, 3'd0, cond_always, 1'b1, 16'h0005);
        add_row(op_mov, 3'd2, 3'd0, cond_always, 1'b1, 16'h8000);
        cond_sweep(3'd1, 16'h0005);
        cond_sweep(3'd1, 16'h0007);
        cond_sweep(3'd1, 16'h0003);
        cond_sweep(3'd2, 16'h0001);
        add_row(op_mov, 3'd5, 3'd0, cond_always, 1'b1, 16'h0300);
        add_row(op_jmp, 3'd5, 3'd0, cond_always, 1'b0, 16'h0000);
        for (int k = 0; k < 24; k++) begin
            rnd = $random(seed);
            add_row(5'd1 + 5'(rnd[7:0] % 8'd14), rnd[11:9], rnd[14:12], cond_always,
                    rnd[8], rnd[31:16]);
        end
        // loads and stores with and without displacement
        add_row(op_mov, 3'd1, 3'd0, cond_always, 1'b1, 16'h1000);
        add_row(op_mov, 3'd2, 3'd0, cond_always, 1'b1, 16'hbeef);
        add_row(op_st,  3'd2, 3'd1, cond_always, 1'b0, 16'h0000);
        add_row(op_ld,  3'd3, 3'd1, cond_always, 1'b0, 16'h0000);
        add_row(op_st,  3'd1, 3'd1, cond_always, 1'b1, 16'h0006);
        add_row(op_ld,  3'd4, 3'd1, cond_always, 1'b1, 16'h0006);
        add_row(op_ld,  3'd5, 3'd1, cond_always, 1'b1, 16'h0021);
        // stack through r7
        add_row(op_mov,  3'd7, 3'd0, cond_always, 1'b1, 16'h2000);
        add_row(op_push, 3'd2, 3'd0, cond_always, 1'b0, 16'h0000);
        add_row(op_push, 3'd0, 3'd0, cond_always, 1'b1, 16'h1234);
        add_row(op_pop,  3'd3, 3'd0, cond_always, 1'b0, 16'h0000);
        add_row(op_pop,  3'd7, 3'd0, cond_always, 1'b0, 16'h0000);
        add_row(op_nop,  3'd0, 3'd0, cond_always, 1'b0, 16'h0000);
        add_row(5'd31,   3'd1, 3'd2, cond_always, 1'b1, 16'hffff);
    endtask

    initial begin
        instr_t      ins;
        logic [31:0] got;
        logic [15:0] a1;
        rst = 1'b1;
        host_req = '0;
        for (int k = 0; k < 65536; k++) begin
            mem[k] = k[7:0] ^ k[15:8] ^ 8'ha5;
            m_mem[k] = k[7:0] ^ k[15:8] ^ 8'ha5;
        end
        for (int k = 0; k < 8; k++) begin
            m_regs[k] = '0;
        end
        m_flags = '0;
        m_pc = '0;
        build_table();

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // everything reads zero out of reset
        for (int k = 0; k < 8; k++) begin
            host_xfer(1'b0, host_adr_reg_base + 16'(k), '0, got);
            check_word("reset register", k, got, 32'h0);
        end
        host_xfer(1'b0, host_adr_flags, '0, got);
        check_word("reset flags", 0, got, 32'h0);
        host_xfer(1'b0, host_adr_pc, '0, got);
        check_word("reset pc", 0, got, 32'h0);

        foreach (table_q[n]) begin
            ins = table_q[n].word;
            host_xfer(1'b1, host_adr_instr, table_q[n].word, got);
            host_xfer(1'b0, host_adr_reg_base + {13'h0000, ins.rd}, '0, got);
            check_word("rd", n, got, {16'h0000, table_q[n].exp_rd});
            host_xfer(1'b0, host_adr_reg_base + 16'd7, '0, got);
            check_word("r7", n, got, {16'h0000, table_q[n].exp_sp});
            host_xfer(1'b0, host_adr_flags, '0, got);
            check_word("flags", n, got, {28'h0000000, table_q[n].exp_flags});
            host_xfer(1'b0, host_adr_pc, '0, got);
            check_word("pc", n, got, {16'h0000, table_q[n].exp_pc});
            if (table_q[n].mem_chk) begin
                a1 = table_q[n].mem_adr + 16'd1;
                check_word("memory word", n, {16'h0000, mem[a1], mem[table_q[n].mem_adr]},
                           {16'h0000, table_q[n].mem_word});
            end
        end

        report_counts();
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
